/* cnn_core.f */
common/cnn_pkg.sv
logic/load_ctrl.sv
logic/kernel_bank.sv
logic/tile_buffer.sv
logic/pe.sv
logic/pool_unit.sv
logic/cnn_core.sv
bench/tb_cnn_core.sv

/* Bender.yml */
package:
  name: cnn_core

sources:
  - files:
      - common/cnn_pkg.sv
      - logic/load_ctrl.sv
      - logic/kernel_bank.sv
      - logic/tile_buffer.sv
      - logic/pe.sv
      - logic/pool_unit.sv
      - logic/cnn_core.sv
  - target: test
    files:
      - bench/tb_cnn_core.sv

/* bench/tb_cnn_core.sv */
`timescale 1ns/1ps

module tb_cnn_core
    import cnn_pkg::*;
();

    localparam int TIMEOUT = 200;

    logic                     clk;
    logic                     rst;
    logic        [WORD_W-1:0] data;
    logic                     valid;
    logic                     ready;
    logic signed [DATA_W-1:0] out_data;
    logic                     out_valid;

    logic signed [DATA_W-1:0] weights [CH_NUM][K_SIZE][K_SIZE];
    logic signed [DATA_W-1:0] pixels  [CH_NUM][TILE_SIZE][TILE_SIZE];

    int seed = 32'h33df_51e2;
    int checks;
    int errors;
    int timeouts;

    cnn_core i_cnn_core (
        .i_clk   (clk),
        .i_rst   (rst),
        .i_data  (data),
        .i_valid (valid),
        .o_ready (ready),
        .o_data  (out_data),
        .o_valid (out_valid)
    );

    always #10 clk = ~clk;

    assert property (@(posedge clk) disable iff (!rst) out_valid |=> !out_valid)
    else
    begin
        errors++;
        $display("o_valid stayed high for more than one cycle");
    end

    // the result comes back together with kernel load
    assert property (@(posedge clk) disable iff (!rst) out_valid |-> ready)
    else
    begin
        errors++;
        $display("o_valid was raised while o_ready was low");
    end

    task automatic check_value(input string name, input int exp, input int act);
        checks++;
        assert (act == exp)
        else
        begin
            errors++;
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // max of the four 3x3x8 sums, shifted and clipped to a byte
    task automatic compute_expected(output int exp);
        int sum;
        int best;
        best = 0;
        for (int r = 0; r < 2; r++)
        begin
            for (int c = 0; c < 2; c++)
            begin
                sum = 0;
                for (int ch = 0; ch < CH_NUM; ch++)
                    for (int i = 0; i < K_SIZE; i++)
                        for (int j = 0; j < K_SIZE; j++)
                            sum += int'(pixels[ch][r+i][c+j]) * int'(weights[ch][i][j]);
                if ((r == 0 && c == 0) || sum > best)
                    best = sum;
            end
        end
        exp = best >>> 8;
        if (exp > 127)
            exp = 127;
        else if (exp < -128)
            exp = -128;
    endtask

    task automatic fill_const(input logic signed [DATA_W-1:0] wv,
                              input logic signed [DATA_W-1:0] pv);
        for (int ch = 0; ch < CH_NUM; ch++)
        begin
            for (int r = 0; r < K_SIZE; r++)
                for (int c = 0; c < K_SIZE; c++)
                    weights[ch][r][c] = wv;
            for (int r = 0; r < TILE_SIZE; r++)
                for (int c = 0; c < TILE_SIZE; c++)
                    pixels[ch][r][c] = pv;
        end
    endtask

    // mode 1 pushes towards +127, mode 2 towards -128
    task automatic fill_job(input int mode);
        logic [DATA_W-1:0] w;
        logic [DATA_W-1:0] p;
        for (int ch = 0; ch < CH_NUM; ch++)
        begin
            for (int r = 0; r < K_SIZE; r++)
            begin
                for (int c = 0; c < K_SIZE; c++)
                begin
                    w = 8'($random(seed));
                    if (mode == 1)
                        w = w & 8'h7f;
                    else if (mode == 2)
                        w = w | 8'h80;                  // always negative
                    weights[ch][r][c] = w;
                end
            end
            for (int r = 0; r < TILE_SIZE; r++)
            begin
                for (int c = 0; c < TILE_SIZE; c++)
                begin
                    p = 8'($random(seed));
                    if (mode != 0)
                        p = p & 8'h7f;
                    pixels[ch][r][c] = p;
                end
            end
        end
    endtask

    // starts and ends on a falling edge
    task automatic send_word(input logic [WORD_W-1:0] w, input bit gaps);
        int idle;
        int waited;
        idle = 0;
        waited = 0;
        if (gaps)
            idle = $unsigned($random(seed)) % 3;
        repeat (idle) @(negedge clk);
        data  = w;
        valid = 1'b1;
        while (!ready && waited < TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        if (!ready)
        begin
            timeouts++;
            $display("Timeout: the DUT never raised o_ready for an input word");
        end
        @(negedge clk);
        valid = 1'b0;
    endtask

    task automatic send_job(input bit gaps);
        for (int ch = 0; ch < CH_NUM; ch++)
            for (int r = 0; r < K_SIZE; r++)
                for (int c = 0; c < K_SIZE; c++)
                    send_word({8'($random(seed)), weights[ch][r][c]}, gaps);   // junk high byte
        for (int ch = 0; ch < CH_NUM; ch++)
            for (int r = 0; r < TILE_SIZE; r++)
                for (int h = 0; h < 2; h++)
                    send_word({pixels[ch][r][2*h+1], pixels[ch][r][2*h]}, gaps);
    endtask

    // k counts falling edges after the edge that took the last image word
    task automatic check_output(input string name, input bit offer);
        int exp;
        int k;
        compute_expected(exp);
        k = 1;
        while (!out_valid && k < TIMEOUT)
        begin
            if (k <= POS_NUM)
                check_value({name, " ready in compute"}, 0, ready);
            if (offer)
            begin
                data  = 16'($random(seed));             // must be ignored
                valid = 1'b1;
            end
            @(negedge clk);
            k++;
        end
        valid = 1'b0;
        if (!out_valid)
        begin
            timeouts++;
            $display("Timeout: no output pulse for %s", name);
        end
        else
        begin
            check_value({name, " latency"}, 5, k);
            check_value({name, " ready at output"}, 1, ready);
            check_value(name, exp, out_data);
            @(negedge clk);
            check_value({name, " pulse width"}, 0, out_valid);
        end
    endtask

    initial
    begin
        clk      = 1'b0;
        rst      = 1'b0;
        data     = '0;
        valid    = 1'b0;
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        repeat (2) @(negedge clk);
        rst = 1'b1;

        check_value("reset o_valid", 0, out_valid);
        check_value("reset o_ready", 1, ready);
        check_value("reset o_data", 0, out_data);

        fill_const(8'sd1, 8'sd1);
        send_job(1'b0);
        check_output("ones job", 1'b0);

        fill_const(8'sd127, 8'sd1);
        pixels[0][1][1] = 8'sd127;                      // in all four windows
        send_job(1'b0);
        check_output("centre pixel job", 1'b0);

        for (int n = 0; n < 3; n++)
        begin
            fill_job(n);
            send_job(1'b0);
            check_output($sformatf("random job %0d", n), 1'b0);
        end

        // same job twice, with words offered in compute, then with gaps
        fill_job(0);
        send_job(1'b0);
        check_output("busy offer job", 1'b1);
        send_job(1'b1);
        check_output("gapped job", 1'b0);

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* logic/cnn_core.sv */
`timescale 1ns/1ps

module cnn_core
    import cnn_pkg::*;
(
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic        [WORD_W-1:0] i_data,
    input  logic                     i_valid,
    output logic                     o_ready,
    output logic signed [DATA_W-1:0] o_data,
    output logic                     o_valid
);

    logic                      kernel_we;
    logic                      image_we;
    logic [2:0]                ch;
    logic [1:0]                row;
    logic [1:0]                col;
    logic [1:0]                pos;
    logic                      first;
    logic                      last;
    logic [CH_NUM*WIN_W-1:0]   kernel_win;
    logic [CH_NUM*WIN_W-1:0]   image_win;
    logic [PE_NUM*ACC_W-1:0]   pe_sums;

    load_ctrl i_load_ctrl (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_valid     (i_valid),
        .o_ready     (o_ready),
        .o_kernel_we (kernel_we),
        .o_image_we  (image_we),
        .o_ch        (ch),
        .o_row       (row),
        .o_col       (col),
        .o_pos       (pos),
        .o_first     (first),
        .o_last      (last)
    );

    kernel_bank i_kernel_bank (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_we      (kernel_we),
        .i_ch      (ch),
        .i_row     (row),
        .i_col     (col),
        .i_data    (i_data),
        .o_windows (kernel_win)
    );

    tile_buffer i_tile_buffer (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_we      (image_we),
        .i_ch      (ch),
        .i_row     (row),
        .i_half    (col[0]),                        // half index in image load
        .i_data    (i_data),
        .i_pos     (pos),
        .o_windows (image_win)
    );

    // pe n takes channels 2n and 2n+1
    for (genvar g = 0; g < PE_NUM; g++)
    begin : g_pe
        pe i_pe (
            .i_pixels  (image_win[g*2*WIN_W +: 2*WIN_W]),
            .i_weights (kernel_win[g*2*WIN_W +: 2*WIN_W]),
            .o_sum     (pe_sums[g*ACC_W +: ACC_W])
        );
    end

    pool_unit i_pool_unit (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_sums  (pe_sums),
        .i_first (first),
        .i_last  (last),
        .o_data  (o_data),
        .o_valid (o_valid)
    );

endmodule

/* logic/pool_unit.sv */
`timescale 1ns/1ps

module pool_unit
    import cnn_pkg::*;
(
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic [PE_NUM*ACC_W-1:0]  i_sums,
    input  logic                     i_first,
    input  logic                     i_last,
    output logic signed [DATA_W-1:0] o_data,
    output logic                     o_valid
);

    logic signed [ACC_W-1:0]  conv_sum;
    logic signed [ACC_W-1:0]  max_q;
    logic signed [ACC_W-1:0]  max_d;
    logic signed [ACC_W-1:0]  pooled;
    logic signed [DATA_W-1:0] sat_byte;

    always_comb
    begin
        conv_sum = '0;
        for (int p = 0; p < PE_NUM; p++)
        begin
            conv_sum = conv_sum + $signed(i_sums[p*ACC_W +: ACC_W]);
        end
    end

    // first position reloads the 2x2 max
    assign max_d  = (i_first || (conv_sum > max_q)) ? conv_sum : max_q;
    assign pooled = max_d >>> OUT_SHIFT;

    always_comb
    begin
        if (pooled > OUT_MAX)
            sat_byte = DATA_W'(OUT_MAX);
        else if (pooled < OUT_MIN)
            sat_byte = DATA_W'(OUT_MIN);
        else
            sat_byte = pooled[DATA_W-1:0];
    end

    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
        begin
            max_q   <= '0;
            o_data  <= '0;
            o_valid <= 1'b0;
        end
        else
        begin
            max_q   <= max_d;
            o_valid <= i_last;                          // one-cycle pulse
            if (i_last)
                o_data <= sat_byte;
        end
    end

endmodule

/* logic/pe.sv */
`timescale 1ns/1ps

module pe
    import cnn_pkg::*;
(
    input  logic        [2*WIN_W-1:0] i_pixels,
    input  logic        [2*WIN_W-1:0] i_weights,
    output logic signed [ACC_W-1:0]   o_sum
);

    logic signed [2*DATA_W-1:0] prod [2*K_SIZE*K_SIZE];

    // 18 taps over two channels
    always_comb
    begin
        for (int t = 0; t < 2 * K_SIZE * K_SIZE; t++)
        begin
            prod[t] = $signed(i_pixels[t*DATA_W +: DATA_W])
                    * $signed(i_weights[t*DATA_W +: DATA_W]);
        end
    end

    always_comb
    begin
        o_sum = '0;
        for (int t = 0; t < 2 * K_SIZE * K_SIZE; t++)
        begin
            o_sum = o_sum + ACC_W'(prod[t]);            // sign extended
        end
    end

endmodule

/* logic/tile_buffer.sv */
`timescale 1ns/1ps

module tile_buffer
    import cnn_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_we,
    input  logic [2:0]              i_ch,
    input  logic [1:0]              i_row,
    input  logic                    i_half,
    input  in_word_u                i_data,
    input  logic [1:0]              i_pos,
    output logic [CH_NUM*WIN_W-1:0] o_windows
);

    logic signed [DATA_W-1:0] pix_q [CH_NUM][TILE_SIZE][TILE_SIZE];
    logic                     row_off;
    logic                     col_off;

    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
        begin
            for (int c = 0; c < CH_NUM; c++)
                for (int r = 0; r < TILE_SIZE; r++)
                    for (int k = 0; k < TILE_SIZE; k++)
                        pix_q[c][r][k] <= '0;
        end
        else if (i_we)
        begin
            // both pixels of the word land in one cycle
            pix_q[i_ch][i_row][{i_half, 1'b0}] <= i_data.pixel.lo;
            pix_q[i_ch][i_row][{i_half, 1'b1}] <= i_data.pixel.hi;
        end
    end

    // positions run (0,0) (0,1) (1,0) (1,1)
    assign row_off = i_pos[1];
    assign col_off = i_pos[0];

    always_comb
    begin
        for (int c = 0; c < CH_NUM; c++)
        begin
            for (int r = 0; r < K_SIZE; r++)
            begin
                for (int k = 0; k < K_SIZE; k++)
                begin
                    o_windows[c*WIN_W + (r*K_SIZE + k)*DATA_W +: DATA_W] =
                        pix_q[c][r + row_off][k + col_off];
                end
            end
        end
    end

endmodule

/* logic/kernel_bank.sv */
`timescale 1ns/1ps

module kernel_bank
    import cnn_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_we,
    input  logic [2:0]              i_ch,
    input  logic [1:0]              i_row,
    input  logic [1:0]              i_col,
    input  in_word_u                i_data,
    output logic [CH_NUM*WIN_W-1:0] o_windows
);

    logic signed [DATA_W-1:0] weight_q [CH_NUM][K_SIZE][K_SIZE];

    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
        begin
            for (int c = 0; c < CH_NUM; c++)
                for (int r = 0; r < K_SIZE; r++)
                    for (int k = 0; k < K_SIZE; k++)
                        weight_q[c][r][k] <= '0;
        end
        else if (i_we)
        begin
            weight_q[i_ch][i_row][i_col] <= i_data.kernel.weight;   // low byte only
        end
    end

    // tap (r,k) of channel c sits at c*WIN_W + (r*3+k)*8
    always_comb
    begin
        for (int c = 0; c < CH_NUM; c++)
        begin
            for (int r = 0; r < K_SIZE; r++)
            begin
                for (int k = 0; k < K_SIZE; k++)
                begin
                    o_windows[c*WIN_W + (r*K_SIZE + k)*DATA_W +: DATA_W] = weight_q[c][r][k];
                end
            end
        end
    end

endmodule

/* logic/load_ctrl.sv */
`timescale 1ns/1ps

module load_ctrl
    import cnn_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_valid,
    output logic       o_ready,
    output logic       o_kernel_we,
    output logic       o_image_we,
    output logic [2:0] o_ch,
    output logic [1:0] o_row,
    output logic [1:0] o_col,
    output logic [1:0] o_pos,
    output logic       o_first,
    output logic       o_last
);

    logic [1:0] state_q;
    logic [2:0] ch_q;
    logic [1:0] row_q;
    logic [1:0] col_q;
    logic [1:0] pos_q;
    logic       accept;
    logic       last_word;
    logic [1:0] col_max;
    logic [1:0] row_max;
    logic [6:0] k_idx;
    logic [5:0] i_idx;

    assign o_ready = (state_q == ST_KERNEL) || (state_q == ST_IMAGE);
    assign accept  = i_valid && o_ready;

    // kernel words are 3x3 per channel, image words are 4 rows of 2 halves
    assign col_max = (state_q == ST_KERNEL) ? 2'(K_SIZE - 1) : 2'(TILE_SIZE / 2 - 1);
    assign row_max = (state_q == ST_KERNEL) ? 2'(K_SIZE - 1) : 2'(TILE_SIZE - 1);

    assign k_idx = 7'(ch_q) * 7'(K_SIZE * K_SIZE) + 7'(row_q) * 7'(K_SIZE) + 7'(col_q);
    assign i_idx = {ch_q, row_q, col_q[0]};

    assign last_word = (state_q == ST_KERNEL) ? (k_idx == 7'(KERNEL_WORDS - 1))
                                              : (i_idx == 6'(IMAGE_WORDS - 1));

    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
        begin
            state_q <= ST_KERNEL;
            ch_q    <= '0;
            row_q   <= '0;
            col_q   <= '0;
            pos_q   <= '0;
        end
        else
        begin
            case (state_q)
                ST_KERNEL, ST_IMAGE:
                begin
                    if (accept)
                    begin
                        if (col_q == col_max)
                        begin
                            col_q <= '0;
                            if (row_q == row_max)
                            begin
                                row_q <= '0;
                                ch_q  <= ch_q + 3'd1;   // wraps to 0 after channel 7
                            end
                            else
                            begin
                                row_q <= row_q + 2'd1;
                            end
                        end
                        else
                        begin
                            col_q <= col_q + 2'd1;
                        end
                        if (last_word)
                        begin
                            state_q <= (state_q == ST_KERNEL) ? ST_IMAGE : ST_COMPUTE;
                        end
                    end
                end
                ST_COMPUTE:
                begin
                    pos_q <= pos_q + 2'd1;
                    if (pos_q == 2'(POS_NUM - 1))
                    begin
                        state_q <= ST_KERNEL;
                    end
                end
                default:
                begin
                    state_q <= ST_KERNEL;
                end
            endcase
        end
    end

    assign o_kernel_we = accept && (state_q == ST_KERNEL);
    assign o_image_we  = accept && (state_q == ST_IMAGE);
    assign o_ch        = ch_q;
    assign o_row       = row_q;
    assign o_col       = col_q;
    assign o_pos       = pos_q;
    assign o_first     = (state_q == ST_COMPUTE) && (pos_q == 2'd0);
    assign o_last      = (state_q == ST_COMPUTE) && (pos_q == 2'(POS_NUM - 1));

endmodule

/* common/cnn_pkg.sv */
package cnn_pkg;

    localparam int DATA_W       = 8;
    localparam int WORD_W       = 16;
    localparam int CH_NUM       = 8;
    localparam int K_SIZE       = 3;
    localparam int TILE_SIZE    = 4;
    localparam int POS_NUM      = 4;
    localparam int KERNEL_WORDS = 72;
    localparam int IMAGE_WORDS  = 64;
    localparam int ACC_W        = 24;
    localparam int OUT_SHIFT    = 8;
    localparam int PE_NUM       = 4;
    localparam int WIN_W        = 72;               // 3x3 taps of one channel

    // saturation bounds of the output byte
    localparam int OUT_MAX      = 127;
    localparam int OUT_MIN      = -128;

    // job states
    localparam logic [1:0] ST_KERNEL  = 2'd0;
    localparam logic [1:0] ST_IMAGE   = 2'd1;
    localparam logic [1:0] ST_COMPUTE = 2'd2;

    typedef struct packed {
        logic        [DATA_W-1:0] unused;           // ignored on kernel words
        logic signed [DATA_W-1:0] weight;
    } kernel_word_t;

    typedef struct packed {
        logic signed [DATA_W-1:0] hi;               // column 2*half+1
        logic signed [DATA_W-1:0] lo;               // column 2*half
    } pixel_word_t;

    // one input word, read by load phase
    typedef union packed {
        kernel_word_t kernel;
        pixel_word_t  pixel;
    } in_word_u;

endpackage
